//--- src/trap_pkg.sv
package trap_pkg;

  // Data and address word
  typedef logic [31:0] word;

  typedef enum logic [1:0] {
    USER_MODE    = 2'b00,
    MACHINE_MODE = 2'b11
  } privilege_t;

  // Synchronous exception codes as recorded in mcause
  typedef enum logic [3:0] {
    EXC_INSTR_MISALIGNED = 4'd0,
    EXC_INSTR_FAULT      = 4'd1,
    EXC_ILLEGAL_INSTR    = 4'd2,
    EXC_BREAKPOINT       = 4'd3,
    EXC_LOAD_MISALIGNED  = 4'd4,
    EXC_LOAD_FAULT       = 4'd5,
    EXC_STORE_MISALIGNED = 4'd6,
    EXC_STORE_FAULT      = 4'd7,
    EXC_ECALL_U          = 4'd8,
    EXC_ECALL_M          = 4'd11
  } exception_t;

  // Byte offsets on the AXI4-Lite CSR port
  localparam logic [11:0] CSR_ADDR_MSTATUS  = 12'h000;
  localparam logic [11:0] CSR_ADDR_MTVEC    = 12'h004;
  localparam logic [11:0] CSR_ADDR_MEPC     = 12'h008;
  localparam logic [11:0] CSR_ADDR_MCAUSE   = 12'h00C;
  localparam logic [11:0] CSR_ADDR_MTVAL    = 12'h010;
  localparam logic [11:0] CSR_ADDR_MTIMECMP = 12'h014;
  localparam logic [11:0] CSR_ADDR_MTIME    = 12'h018;

  // mstatus field positions
  localparam int MSTATUS_MIE_BIT  = 3;
  localparam int MSTATUS_MPIE_BIT = 7;
  localparam int MSTATUS_MPP_LSB  = 11;

  // Only the machine timer can interrupt
  localparam logic [30:0] IRQ_CAUSE_TIMER = 31'd7;

  localparam logic [1:0] AXI_RESP_OKAY   = 2'b00;
  localparam logic [1:0] AXI_RESP_SLVERR = 2'b10;

endpackage

//--- src/trap_fsm.sv
`timescale 1ns/1ps

module trap_fsm
  import trap_pkg::*;
(
  input  logic       clk_core,
  input  logic       rst_core_n,
  input  logic       irq_i,

  input  logic       flush_ack_i,
  output logic       flush_req_o,
  output word        flush_target_o,

  input  logic       ctrl_flush_begin_i,
  input  logic       ctrl_trap_i,
  input  exception_t ctrl_trap_cause_i,
  input  word        ctrl_trap_value_i,
  input  word        ctrl_next_pc_i,
  input  logic       ctrl_mode_return_i,
  input  logic       ctrl_commit_i,
  input  logic       ctrl_wait_irq_i,
  output logic       begin_irq_o,

  input  logic       mstatus_mie_i,
  input  logic       mstatus_mpie_i,
  input  privilege_t mstatus_mpp_i,
  input  word        mepc_i,
  input  word        mtvec_i,

  output logic       mie_we_o,
  output logic       mie_next_o,
  output logic       mpie_we_o,
  output logic       mpie_next_o,
  output logic       mpp_we_o,
  output privilege_t mpp_next_o,
  output logic       trap_we_o,
  output word        mepc_next_o,
  output word        mcause_next_o,
  output word        mtval_next_o,

  output privilege_t current_mode_o
);

  typedef enum logic [2:0] {
    SETTLE,
    FLUSH_ENTER,
    FLUSH_EXIT,
    RUN,
    IRQ_PENDING,
    WAIT_FOR_IRQ
  } state_t;

  state_t state_q, state_d;
  logic irq_pending_q, take_irq_q, woke_q;
  logic interrupt_enable, mpp_legal, do_return, trap_entry;
  logic jump, mode_switch, wait_for_irq;
  privilege_t mpp_safe, to_mode;
  word jump_address;

  // An interrupt entry outranks a stale return request
  assign do_return  = ctrl_mode_return_i & ~take_irq_q;
  assign trap_entry = (ctrl_trap_i | take_irq_q) & ~do_return;

  // User mode can always be interrupted
  assign interrupt_enable = (current_mode_o == USER_MODE) | mstatus_mie_i;

  // Only machine and user modes exist
  assign mpp_legal = (mstatus_mpp_i == USER_MODE) || (mstatus_mpp_i == MACHINE_MODE);
  assign mpp_safe  = mpp_legal ? mstatus_mpp_i : current_mode_o;
  assign to_mode   = do_return ? mpp_safe : MACHINE_MODE;

  always_comb begin
    state_d      = state_q;
    flush_req_o  = 1'b0;
    begin_irq_o  = 1'b0;
    jump         = 1'b0;
    mode_switch  = 1'b0;
    wait_for_irq = 1'b0;

    case (state_q)
      SETTLE: begin
        jump        = 1'b1;
        flush_req_o = 1'b1;
        mode_switch = trap_entry | do_return;
        state_d     = (ctrl_wait_irq_i & ~woke_q) ? WAIT_FOR_IRQ : FLUSH_ENTER;
      end
      FLUSH_ENTER: begin
        flush_req_o = 1'b1;
        if (flush_ack_i) state_d = FLUSH_EXIT;
      end
      FLUSH_EXIT: begin
        if (!flush_ack_i) state_d = RUN;
      end
      RUN: begin
        if (ctrl_flush_begin_i) state_d = SETTLE;
        else if (irq_pending_q) state_d = IRQ_PENDING;
      end
      IRQ_PENDING: begin
        begin_irq_o = 1'b1;
        if (ctrl_flush_begin_i | ctrl_commit_i) state_d = SETTLE;
      end
      WAIT_FOR_IRQ: begin
        flush_req_o  = 1'b1;
        wait_for_irq = 1'b1;
        if (irq_i) state_d = SETTLE;
      end
      default: state_d = SETTLE;
    endcase

    if (trap_entry) jump_address = mtvec_i;
    else if (do_return) jump_address = mepc_i;
    else jump_address = ctrl_next_pc_i;
  end

  assign mie_we_o    = mode_switch;
  assign mie_next_o  = do_return ? mstatus_mpie_i : 1'b0;
  assign mpie_we_o   = mode_switch;
  assign mpie_next_o = do_return ? 1'b1 : mstatus_mie_i;

  // Illegal MPP is overwritten with the current mode
  assign mpp_we_o   = mode_switch | ~mpp_legal;
  assign mpp_next_o = (mode_switch & do_return) ? USER_MODE : current_mode_o;

  assign trap_we_o     = mode_switch & trap_entry;
  assign mepc_next_o   = {ctrl_next_pc_i[31:2], 2'b00};
  assign mcause_next_o = take_irq_q ? {1'b1, IRQ_CAUSE_TIMER} : {28'd0, ctrl_trap_cause_i};
  assign mtval_next_o  = take_irq_q ? '0 : ctrl_trap_value_i;

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      state_q        <= SETTLE;
      current_mode_o <= MACHINE_MODE;
      irq_pending_q  <= 1'b0;
      take_irq_q     <= 1'b0;
      woke_q         <= 1'b0;
    end else begin
      state_q       <= state_d;
      irq_pending_q <= irq_i & interrupt_enable;
      // Interrupt is taken once the core stops, unless its own flush came first
      take_irq_q    <= (begin_irq_o & ~ctrl_flush_begin_i) | (wait_for_irq & interrupt_enable);
      woke_q        <= wait_for_irq;
      if (mode_switch) current_mode_o <= to_mode;
    end
  end

  always_ff @(posedge clk_core) begin
    if (jump) flush_target_o <= jump_address;
  end

endmodule

//--- src/csr_file.sv
`timescale 1ns/1ps

module csr_file
  import trap_pkg::*;
(
  input  logic       clk_core,
  input  logic       rst_core_n,

  input  logic       mie_we_i,
  input  logic       mie_next_i,
  input  logic       mpie_we_i,
  input  logic       mpie_next_i,
  input  logic       mpp_we_i,
  input  privilege_t mpp_next_i,
  input  logic       trap_we_i,
  input  word        mepc_next_i,
  input  word        mcause_next_i,
  input  word        mtval_next_i,

  output logic       mstatus_mie_o,
  output logic       mstatus_mpie_o,
  output privilege_t mstatus_mpp_o,
  output word        mepc_o,
  output word        mtvec_o,
  output word        mtimecmp_o,
  input  word        mtime_i,

  input  word        s_awaddr_i,
  input  logic       s_awvalid_i,
  output logic       s_awready_o,
  input  word        s_wdata_i,
  input  logic [3:0] s_wstrb_i,
  input  logic       s_wvalid_i,
  output logic       s_wready_o,
  output logic [1:0] s_bresp_o,
  output logic       s_bvalid_o,
  input  logic       s_bready_i,
  input  word        s_araddr_i,
  input  logic       s_arvalid_i,
  output logic       s_arready_o,
  output word        s_rdata_o,
  output logic [1:0] s_rresp_o,
  output logic       s_rvalid_o,
  input  logic       s_rready_i
);

  word mcause_q, mtval_q;
  word mstatus_word, wr_old, wr_data, rd_data;
  logic wr_hit, rd_hit, wr_accept, rd_accept;

  function automatic word apply_strb(word old_value, word new_value, logic [3:0] strb);
    word result;
    for (int i = 0; i < 4; i++) begin
      result[8*i +: 8] = strb[i] ? new_value[8*i +: 8] : old_value[8*i +: 8];
    end
    return result;
  endfunction

  // Current value at an offset, zero and no hit when unmapped
  function automatic word csr_lookup(word addr, output logic hit);
    word value;
    value = '0;
    hit   = (addr[31:12] == '0);
    case (addr[11:0])
      CSR_ADDR_MSTATUS:  value = mstatus_word;
      CSR_ADDR_MTVEC:    value = mtvec_o;
      CSR_ADDR_MEPC:     value = mepc_o;
      CSR_ADDR_MCAUSE:   value = mcause_q;
      CSR_ADDR_MTVAL:    value = mtval_q;
      CSR_ADDR_MTIMECMP: value = mtimecmp_o;
      CSR_ADDR_MTIME:    value = mtime_i;
      default:           hit = 1'b0;
    endcase
    if (!hit) value = '0;
    return value;
  endfunction

  always_comb begin
    mstatus_word = '0;
    mstatus_word[MSTATUS_MIE_BIT]      = mstatus_mie_o;
    mstatus_word[MSTATUS_MPIE_BIT]     = mstatus_mpie_o;
    mstatus_word[MSTATUS_MPP_LSB +: 2] = mstatus_mpp_o;

    wr_old  = csr_lookup(s_awaddr_i, wr_hit);
    wr_data = apply_strb(wr_old, s_wdata_i, s_wstrb_i);
    rd_data = csr_lookup(s_araddr_i, rd_hit);
  end

  // One transaction per direction in flight
  assign wr_accept = s_awvalid_i & s_wvalid_i & ~s_awready_o & ~s_bvalid_o;
  assign rd_accept = s_arvalid_i & ~s_arready_o & ~s_rvalid_o;

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      s_awready_o <= 1'b0;
      s_wready_o  <= 1'b0;
      s_bvalid_o  <= 1'b0;
      s_arready_o <= 1'b0;
      s_rvalid_o  <= 1'b0;
    end else begin
      s_awready_o <= wr_accept;
      s_wready_o  <= wr_accept;
      s_arready_o <= rd_accept;
      if (s_awready_o) s_bvalid_o <= 1'b1;
      else if (s_bready_i) s_bvalid_o <= 1'b0;
      if (s_arready_o) s_rvalid_o <= 1'b1;
      else if (s_rready_i) s_rvalid_o <= 1'b0;
    end
  end

  always_ff @(posedge clk_core) begin
    if (s_awready_o) s_bresp_o <= wr_hit ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
    if (s_arready_o) begin
      s_rdata_o <= rd_data;
      s_rresp_o <= rd_hit ? AXI_RESP_OKAY : AXI_RESP_SLVERR;
    end
  end

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      mstatus_mie_o  <= 1'b0;
      mstatus_mpie_o <= 1'b0;
      mstatus_mpp_o  <= MACHINE_MODE;
      mepc_o         <= '0;
      mtvec_o        <= '0;
      mcause_q       <= '0;
      mtval_q        <= '0;
      mtimecmp_o     <= '1;
    end else begin
      if (s_awready_o && wr_hit) begin
        case (s_awaddr_i[11:0])
          CSR_ADDR_MSTATUS: begin
            mstatus_mie_o  <= wr_data[MSTATUS_MIE_BIT];
            mstatus_mpie_o <= wr_data[MSTATUS_MPIE_BIT];
            mstatus_mpp_o  <= privilege_t'(wr_data[MSTATUS_MPP_LSB +: 2]);
          end
          CSR_ADDR_MTVEC:    mtvec_o    <= {wr_data[31:2], 2'b00};
          CSR_ADDR_MEPC:     mepc_o     <= {wr_data[31:2], 2'b00};
          CSR_ADDR_MCAUSE:   mcause_q   <= wr_data;
          CSR_ADDR_MTVAL:    mtval_q    <= wr_data;
          CSR_ADDR_MTIMECMP: mtimecmp_o <= wr_data;
          default: ;
        endcase
      end
      // Hardware updates land last so they win
      if (mie_we_i) mstatus_mie_o <= mie_next_i;
      if (mpie_we_i) mstatus_mpie_o <= mpie_next_i;
      if (mpp_we_i) mstatus_mpp_o <= mpp_next_i;
      if (trap_we_i) begin
        mepc_o   <= mepc_next_i;
        mcause_q <= mcause_next_i;
        mtval_q  <= mtval_next_i;
      end
    end
  end

endmodule

//--- src/mtimer.sv
`timescale 1ns/1ps

module mtimer
  import trap_pkg::*;
(
  input  logic clk_core,
  input  logic rst_core_n,
  input  word  mtimecmp_i,
  output word  mtime_o,
  output logic timer_irq_o
);

  logic cmp_hit;

  // Unsigned compare, level until mtimecmp moves past mtime
  assign cmp_hit = (mtime_o >= mtimecmp_i);

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      mtime_o <= '0;
    end else begin
      mtime_o <= mtime_o + 32'd1;
    end
  end

  always_ff @(posedge clk_core or negedge rst_core_n) begin
    if (!rst_core_n) begin
      timer_irq_o <= 1'b0;
    end else begin
      timer_irq_o <= cmp_hit;
    end
  end

endmodule

//--- src/trap_unit_top.sv
`timescale 1ns/1ps

module trap_unit_top
  import trap_pkg::*;
(
  input  logic       clk_core,
  input  logic       rst_core_n,
  input  logic       flush_ack_i,
  output logic       flush_req_o,
  output word        flush_target_o,
  input  logic       ctrl_flush_begin_i,
  input  logic       ctrl_trap_i,
  input  exception_t ctrl_trap_cause_i,
  input  word        ctrl_trap_value_i,
  input  word        ctrl_next_pc_i,
  input  logic       ctrl_mode_return_i,
  input  logic       ctrl_commit_i,
  input  logic       ctrl_wait_irq_i,
  output logic       begin_irq_o,
  output privilege_t current_mode_o,

  input  word        s_awaddr_i,
  input  logic       s_awvalid_i,
  output logic       s_awready_o,
  input  word        s_wdata_i,
  input  logic [3:0] s_wstrb_i,
  input  logic       s_wvalid_i,
  output logic       s_wready_o,
  output logic [1:0] s_bresp_o,
  output logic       s_bvalid_o,
  input  logic       s_bready_i,
  input  word        s_araddr_i,
  input  logic       s_arvalid_i,
  output logic       s_arready_o,
  output word        s_rdata_o,
  output logic [1:0] s_rresp_o,
  output logic       s_rvalid_o,
  input  logic       s_rready_i
);

  logic timer_irq;
  logic mstatus_mie, mstatus_mpie;
  privilege_t mstatus_mpp;
  word mepc, mtvec, mtimecmp, mtime;
  logic mie_we, mie_next, mpie_we, mpie_next, mpp_we, trap_we;
  privilege_t mpp_next;
  word mepc_next, mcause_next, mtval_next;

  trap_fsm u_fsm (
    .clk_core           (clk_core),
    .rst_core_n         (rst_core_n),
    .irq_i              (timer_irq),
    .flush_ack_i        (flush_ack_i),
    .flush_req_o        (flush_req_o),
    .flush_target_o     (flush_target_o),
    .ctrl_flush_begin_i (ctrl_flush_begin_i),
    .ctrl_trap_i        (ctrl_trap_i),
    .ctrl_trap_cause_i  (ctrl_trap_cause_i),
    .ctrl_trap_value_i  (ctrl_trap_value_i),
    .ctrl_next_pc_i     (ctrl_next_pc_i),
    .ctrl_mode_return_i (ctrl_mode_return_i),
    .ctrl_commit_i      (ctrl_commit_i),
    .ctrl_wait_irq_i    (ctrl_wait_irq_i),
    .begin_irq_o        (begin_irq_o),
    .mstatus_mie_i      (mstatus_mie),
    .mstatus_mpie_i     (mstatus_mpie),
    .mstatus_mpp_i      (mstatus_mpp),
    .mepc_i             (mepc),
    .mtvec_i            (mtvec),
    .mie_we_o           (mie_we),
    .mie_next_o         (mie_next),
    .mpie_we_o          (mpie_we),
    .mpie_next_o        (mpie_next),
    .mpp_we_o           (mpp_we),
    .mpp_next_o         (mpp_next),
    .trap_we_o          (trap_we),
    .mepc_next_o        (mepc_next),
    .mcause_next_o      (mcause_next),
    .mtval_next_o       (mtval_next),
    .current_mode_o     (current_mode_o)
  );

  csr_file u_csr (
    .clk_core       (clk_core),
    .rst_core_n     (rst_core_n),
    .mie_we_i       (mie_we),
    .mie_next_i     (mie_next),
    .mpie_we_i      (mpie_we),
    .mpie_next_i    (mpie_next),
    .mpp_we_i       (mpp_we),
    .mpp_next_i     (mpp_next),
    .trap_we_i      (trap_we),
    .mepc_next_i    (mepc_next),
    .mcause_next_i  (mcause_next),
    .mtval_next_i   (mtval_next),
    .mstatus_mie_o  (mstatus_mie),
    .mstatus_mpie_o (mstatus_mpie),
    .mstatus_mpp_o  (mstatus_mpp),
    .mepc_o         (mepc),
    .mtvec_o        (mtvec),
    .mtimecmp_o     (mtimecmp),
    .mtime_i        (mtime),
    .s_awaddr_i     (s_awaddr_i),
    .s_awvalid_i    (s_awvalid_i),
    .s_awready_o    (s_awready_o),
    .s_wdata_i      (s_wdata_i),
    .s_wstrb_i      (s_wstrb_i),
    .s_wvalid_i     (s_wvalid_i),
    .s_wready_o     (s_wready_o),
    .s_bresp_o      (s_bresp_o),
    .s_bvalid_o     (s_bvalid_o),
    .s_bready_i     (s_bready_i),
    .s_araddr_i     (s_araddr_i),
    .s_arvalid_i    (s_arvalid_i),
    .s_arready_o    (s_arready_o),
    .s_rdata_o      (s_rdata_o),
    .s_rresp_o      (s_rresp_o),
    .s_rvalid_o     (s_rvalid_o),
    .s_rready_i     (s_rready_i)
  );

  mtimer u_timer (
    .clk_core    (clk_core),
    .rst_core_n  (rst_core_n),
    .mtimecmp_i  (mtimecmp),
    .mtime_o     (mtime),
    .timer_irq_o (timer_irq)
  );

endmodule

//--- verification/tb_trap_unit.sv
`timescale 1ns/1ps

module tb_trap_unit
  import trap_pkg::*;
();

  typedef enum int {EV_FLUSH, EV_TRAP, EV_RETURN, EV_IRQ} event_t;

  logic clk_core, rst_core_n;
  logic flush_ack_i, flush_req_o, begin_irq_o;
  word flush_target_o, ctrl_trap_value_i, ctrl_next_pc_i;
  logic ctrl_flush_begin_i, ctrl_trap_i, ctrl_mode_return_i, ctrl_commit_i, ctrl_wait_irq_i;
  exception_t ctrl_trap_cause_i;
  privilege_t current_mode_o;
  word s_awaddr_i, s_wdata_i, s_araddr_i, s_rdata_o;
  logic [3:0] s_wstrb_i;
  logic [1:0] s_bresp_o, s_rresp_o;
  logic s_awvalid_i, s_awready_o, s_wvalid_i, s_wready_o, s_bvalid_o, s_bready_i;
  logic s_arvalid_i, s_arready_o, s_rvalid_o, s_rready_i;

  // Reference model state
  logic m_mie, m_mpie;
  privilege_t m_mpp, m_mode;
  word m_mepc, m_mcause, m_mtval, m_mtvec, m_mtimecmp;
  logic [15:0] lfsr_main, lfsr_ack;

  trap_unit_top DUT (.*);

  initial begin
    clk_core = 1'b0;
    forever #50 clk_core = ~clk_core;
  end

  task automatic tick();
    @(posedge clk_core);
    #10;
  endtask

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Verification failed");
    $fatal(1);
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic word lfsr_take(inout logic [15:0] st, input int n);
    word v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      v  = {v[30:0], st[0]};
      st = (st >> 1) ^ (st[0] ? 16'hB400 : 16'h0000);
    end
    return v;
  endfunction

  task automatic check_word(input string name, input word got, input word exp);
    if (got !== exp) begin
      $display("FAILED %s got 0x%08h expected 0x%08h", name, got, exp);
      abort_run("word mismatch");
    end
  endtask

  task automatic check_mode(input string name, input privilege_t got, input privilege_t exp);
    if (got !== exp) begin
      $display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
      abort_run("privilege mode mismatch");
    end
  endtask

  task automatic check_resp(input string name, input logic [1:0] got, input logic [1:0] exp);
    if (got !== exp) begin
      $display("FAILED %s got 0x%h expected 0x%h", name, got, exp);
      abort_run("AXI response mismatch");
    end
  endtask

  function automatic word model_read(logic [11:0] addr);
    word w;
    w = '0;
    case (addr)
      CSR_ADDR_MSTATUS: begin
        w[MSTATUS_MIE_BIT]      = m_mie;
        w[MSTATUS_MPIE_BIT]     = m_mpie;
        w[MSTATUS_MPP_LSB +: 2] = m_mpp;
      end
      CSR_ADDR_MTVEC:    w = m_mtvec;
      CSR_ADDR_MEPC:     w = m_mepc;
      CSR_ADDR_MCAUSE:   w = m_mcause;
      CSR_ADDR_MTVAL:    w = m_mtval;
      CSR_ADDR_MTIMECMP: w = m_mtimecmp;
      default:           w = '0;
    endcase
    return w;
  endfunction

  function automatic void model_write(logic [11:0] addr, word data, logic [3:0] strb);
    word m;
    m = model_read(addr);
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) m[8*i +: 8] = data[8*i +: 8];
    end
    case (addr)
      CSR_ADDR_MSTATUS: begin
        m_mie  = m[MSTATUS_MIE_BIT];
        m_mpie = m[MSTATUS_MPIE_BIT];
        m_mpp  = privilege_t'(m[MSTATUS_MPP_LSB +: 2]);
        // Unsupported MPP falls back to the current mode
        if (m_mpp != USER_MODE && m_mpp != MACHINE_MODE) m_mpp = m_mode;
      end
      CSR_ADDR_MTVEC:    m_mtvec = {m[31:2], 2'b00};
      CSR_ADDR_MEPC:     m_mepc = {m[31:2], 2'b00};
      CSR_ADDR_MCAUSE:   m_mcause = m;
      CSR_ADDR_MTVAL:    m_mtval = m;
      CSR_ADDR_MTIMECMP: m_mtimecmp = m;
      default: ;
    endcase
  endfunction

  // Returns the expected restart address and updates the model
  function automatic word model_event(event_t kind, exception_t cause, word value, word pc);
    word target;
    target = pc;
    if (kind == EV_TRAP || kind == EV_IRQ) begin
      target   = m_mtvec;
      m_mpie   = m_mie;
      m_mie    = 1'b0;
      m_mpp    = m_mode;
      m_mode   = MACHINE_MODE;
      m_mepc   = {pc[31:2], 2'b00};
      m_mcause = (kind == EV_TRAP) ? {28'd0, cause} : 32'h8000_0007;
      m_mtval  = (kind == EV_TRAP) ? value : 32'd0;
    end else if (kind == EV_RETURN) begin
      target = m_mepc;
      m_mie  = m_mpie;
      m_mpie = 1'b1;
      m_mode = m_mpp;
      m_mpp  = USER_MODE;
    end
    return target;
  endfunction

  task automatic axi_write(input logic [11:0] addr, input word data, input logic [3:0] strb,
                           output logic [1:0] resp);
    int n;
    s_awaddr_i  = {20'd0, addr};
    s_wdata_i   = data;
    s_wstrb_i   = strb;
    s_awvalid_i = 1'b1;
    s_wvalid_i  = 1'b1;
    n = 0;
    while (!(s_awready_o && s_wready_o)) begin
      tick();
      n++;
      if (n > 50) abort_run("AXI write was never accepted");
    end
    // Handshake completes on the next edge
    tick();
    s_awvalid_i = 1'b0;
    s_wvalid_i  = 1'b0;
    n = 0;
    while (!s_bvalid_o) begin
      tick();
      n++;
      if (n > 50) abort_run("AXI write response never arrived");
    end
    resp = s_bresp_o;
    s_bready_i = 1'b1;
    tick();
    s_bready_i = 1'b0;
  endtask

  task automatic axi_read(input logic [11:0] addr, output word data, output logic [1:0] resp);
    int n;
    s_araddr_i  = {20'd0, addr};
    s_arvalid_i = 1'b1;
    n = 0;
    while (!s_arready_o) begin
      tick();
      n++;
      if (n > 50) abort_run("AXI read was never accepted");
    end
    tick();
    s_arvalid_i = 1'b0;
    n = 0;
    while (!s_rvalid_o) begin
      tick();
      n++;
      if (n > 50) abort_run("AXI read data never arrived");
    end
    data = s_rdata_o;
    resp = s_rresp_o;
    s_rready_i = 1'b1;
    tick();
    s_rready_i = 1'b0;
  endtask

  task automatic write_csr(input logic [11:0] addr, input word data, input logic [3:0] strb);
    logic [1:0] r;
    axi_write(addr, data, strb, r);
    check_resp("s_bresp_o", r, AXI_RESP_OKAY);
    model_write(addr, data, strb);
  endtask

  task automatic read_expect(input logic [11:0] addr, input string name);
    word d;
    logic [1:0] r;
    axi_read(addr, d, r);
    check_resp("s_rresp_o", r, AXI_RESP_OKAY);
    check_word(name, d, model_read(addr));
  endtask

  task automatic wait_req(input logic level, input int limit);
    int n;
    n = 0;
    while (flush_req_o !== level) begin
      tick();
      n++;
      if (n > limit) abort_run("flush_req_o did not reach the expected level in time");
    end
  endtask

  task automatic flush_event(input event_t kind, input exception_t cause, input word value,
                             input word pc);
    ctrl_trap_i        = (kind == EV_TRAP);
    ctrl_trap_cause_i  = cause;
    ctrl_trap_value_i  = value;
    ctrl_mode_return_i = (kind == EV_RETURN);
    ctrl_next_pc_i     = pc;
    ctrl_flush_begin_i = 1'b1;
    wait_req(1'b1, 20);
    ctrl_flush_begin_i = 1'b0;
    wait_req(1'b0, 50);
    check_word("flush_target_o", flush_target_o, model_event(kind, cause, value, pc));
    check_mode("current_mode_o", current_mode_o, m_mode);
    ctrl_trap_i        = 1'b0;
    ctrl_mode_return_i = 1'b0;
  endtask

  // Pipeline side of the flush handshake with random latency
  initial begin
    word d;
    int n;
    flush_ack_i = 1'b0;
    lfsr_ack = 16'd28920;
    n = 0;
    while (rst_core_n !== 1'b1) begin
      tick();
      n++;
      if (n > 100) abort_run("reset was never released");
    end
    forever begin
      wait_req(1'b1, 5000);
      d = lfsr_take(lfsr_ack, 2);
      repeat (d[1:0]) tick();
      flush_ack_i = 1'b1;
      wait_req(1'b0, 5000);
      flush_ack_i = 1'b0;
      tick();
    end
  end

  initial begin
    word a, b, pc, val;
    logic [1:0] r;
    exception_t cause;
    int n;

    rst_core_n = 1'b0;
    ctrl_flush_begin_i = 1'b0;
    ctrl_trap_i = 1'b0;
    ctrl_trap_cause_i = EXC_ILLEGAL_INSTR;
    ctrl_trap_value_i = '0;
    ctrl_next_pc_i = 32'h0000_0100;
    ctrl_mode_return_i = 1'b0;
    ctrl_commit_i = 1'b0;
    ctrl_wait_irq_i = 1'b0;
    s_awaddr_i = '0;
    s_awvalid_i = 1'b0;
    s_wdata_i = '0;
    s_wstrb_i = '0;
    s_wvalid_i = 1'b0;
    s_bready_i = 1'b0;
    s_araddr_i = '0;
    s_arvalid_i = 1'b0;
    s_rready_i = 1'b0;
    lfsr_main = 16'd28920;
    m_mie = 1'b0;
    m_mpie = 1'b0;
    m_mpp = MACHINE_MODE;
    m_mode = MACHINE_MODE;
    m_mepc = '0;
    m_mcause = '0;
    m_mtval = '0;
    m_mtvec = '0;
    m_mtimecmp = '1;
    repeat (16) @(posedge clk_core);
    #10;
    rst_core_n = 1'b1;

    // 1 boot flush
    if (!flush_req_o) abort_run("flush_req_o was low right after reset");
    check_mode("current_mode_o", current_mode_o, MACHINE_MODE);
    wait_req(1'b0, 50);
    check_word("flush_target_o", flush_target_o, model_event(EV_FLUSH, cause, 0, 32'h100));

    // 2 CSR access
    a = lfsr_take(lfsr_main, 32);
    write_csr(CSR_ADDR_MTVEC, a, 4'hF);
    read_expect(CSR_ADDR_MTVEC, "mtvec");
    a = lfsr_take(lfsr_main, 32);
    write_csr(CSR_ADDR_MTVEC, a, 4'b0101);
    read_expect(CSR_ADDR_MTVEC, "mtvec");
    a = lfsr_take(lfsr_main, 32);
    write_csr(CSR_ADDR_MEPC, a, 4'hF);
    read_expect(CSR_ADDR_MEPC, "mepc");
    a = lfsr_take(lfsr_main, 32);
    write_csr(CSR_ADDR_MSTATUS, a, 4'hF);
    read_expect(CSR_ADDR_MSTATUS, "mstatus");
    a = lfsr_take(lfsr_main, 32);
    write_csr(CSR_ADDR_MTIMECMP, a | 32'h8000_0000, 4'hF);
    read_expect(CSR_ADDR_MTIMECMP, "mtimecmp");
    write_csr(CSR_ADDR_MTIMECMP, 32'hFFFF_FFFF, 4'hF);
    read_expect(CSR_ADDR_MCAUSE, "mcause");
    axi_read(CSR_ADDR_MTIME, a, r);
    axi_read(CSR_ADDR_MTIME, b, r);
    if (b <= a) abort_run("mtime did not advance between two reads");
    axi_write(12'h01C, 32'h1234_5678, 4'hF, r);
    check_resp("s_bresp_o", r, AXI_RESP_SLVERR);
    axi_read(12'h01C, a, r);
    check_resp("s_rresp_o", r, AXI_RESP_SLVERR);
    check_word("s_rdata_o", a, 32'd0);

    // 3 synchronous trap with MIE set
    write_csr(CSR_ADDR_MSTATUS, 32'h0000_1808, 4'hF);
    a = lfsr_take(lfsr_main, 4);
    cause = (a[3:0] > 4'd8) ? EXC_ECALL_M : exception_t'(a[3:0]);
    val = lfsr_take(lfsr_main, 32);
    pc = lfsr_take(lfsr_main, 32);
    flush_event(EV_TRAP, cause, val, pc);
    read_expect(CSR_ADDR_MEPC, "mepc");
    read_expect(CSR_ADDR_MCAUSE, "mcause");
    read_expect(CSR_ADDR_MTVAL, "mtval");
    read_expect(CSR_ADDR_MSTATUS, "mstatus");

    // 4 return to user mode
    write_csr(CSR_ADDR_MSTATUS, 32'h0000_0080, 4'hF);
    a = lfsr_take(lfsr_main, 32);
    write_csr(CSR_ADDR_MEPC, a, 4'hF);
    flush_event(EV_RETURN, cause, 0, 32'h0000_0200);
    check_mode("current_mode_o", current_mode_o, USER_MODE);
    read_expect(CSR_ADDR_MSTATUS, "mstatus");

    // 5 timer interrupt
    write_csr(CSR_ADDR_MSTATUS, 32'h0000_0088, 4'hF);
    axi_read(CSR_ADDR_MTIME, a, r);
    write_csr(CSR_ADDR_MTIMECMP, a + 32'd40, 4'hF);
    n = 0;
    while (!begin_irq_o) begin
      tick();
      n++;
      if (n > 300) abort_run("begin_irq_o never rose after the timer compare");
    end
    pc = lfsr_take(lfsr_main, 32);
    ctrl_next_pc_i = pc;
    ctrl_commit_i = 1'b1;
    wait_req(1'b1, 20);
    ctrl_commit_i = 1'b0;
    wait_req(1'b0, 50);
    check_word("flush_target_o", flush_target_o, model_event(EV_IRQ, cause, 0, pc));
    check_mode("current_mode_o", current_mode_o, m_mode);
    axi_read(CSR_ADDR_MCAUSE, a, r);
    check_word("mcause", a, 32'h8000_0007);
    read_expect(CSR_ADDR_MEPC, "mepc");
    read_expect(CSR_ADDR_MSTATUS, "mstatus");
    write_csr(CSR_ADDR_MTIMECMP, 32'hFFFF_FFFF, 4'hF);

    // 6 wait for interrupt
    write_csr(CSR_ADDR_MSTATUS, 32'h0000_1808, 4'hF);
    pc = lfsr_take(lfsr_main, 32);
    ctrl_wait_irq_i = 1'b1;
    ctrl_next_pc_i = pc;
    ctrl_flush_begin_i = 1'b1;
    wait_req(1'b1, 20);
    ctrl_flush_begin_i = 1'b0;
    repeat (8) begin
      tick();
      if (!flush_req_o) abort_run("flush_req_o dropped while waiting for an interrupt");
    end
    axi_read(CSR_ADDR_MTIME, a, r);
    write_csr(CSR_ADDR_MTIMECMP, a + 32'd20, 4'hF);
    wait_req(1'b0, 300);
    check_word("flush_target_o", flush_target_o, model_event(EV_IRQ, cause, 0, pc));
    check_mode("current_mode_o", current_mode_o, m_mode);
    ctrl_wait_irq_i = 1'b0;
    read_expect(CSR_ADDR_MCAUSE, "mcause");
    read_expect(CSR_ADDR_MEPC, "mepc");
    read_expect(CSR_ADDR_MSTATUS, "mstatus");

    $display("Verification passed");
    $finish;
  end

endmodule

//--- flist.f
src/trap_pkg.sv
src/trap_fsm.sv
src/csr_file.sv
src/mtimer.sv
src/trap_unit_top.sv
verification/tb_trap_unit.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing -f flist.f --top-module tb_trap_unit -o sim_trap_unit
./obj_dir/sim_trap_unit > sim.log 2>&1 || true
cat sim.log
if grep -q "Verification failed" sim.log; then
  exit 1
fi
if ! grep -q "Verification passed" sim.log; then
  exit 1
fi
exit 0
